/* source/drive_mode_pkg.sv */
/*
 * Drive model and clock-state definitions for the disk drive board logic.
 * Imported by the clock control, the address decoder and the top level,
 * wherever the model select or the acceleration state is decoded.
 */
`default_nettype none

package drive_mode_pkg;

	// board variant, picks the memory map and the clock options
	typedef enum logic [1:0]
	{
		model_1541 = 2'd0,
		model_1570 = 2'd1,
		model_1571 = 2'd2
	} drive_model_e;

	// bus clock selection state
	typedef enum logic [1:0]
	{
		clk_slow   = 2'd0,  // 1 MHz strobes
		clk_switch = 2'd1,  // halt for one slow strobe
		clk_fast   = 2'd2   // 2 MHz strobes
	} clk_state_e;

	// jumper-set drive number, seen on VIA1 PB6-PB5
	typedef logic [1:0] drive_num_t;

endpackage

`default_nettype wire

/* source/drive_bus_pkg.sv */
/*
 * CPU bus definitions for the drive board logic.
 * Holds the bus widths, the RAM sizes and the register index map
 * of the reduced 6522 port blocks.
 */
`default_nettype none

package drive_bus_pkg;

	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  cpu_data_t;

	// ----------------------------------------
	// memory sizes
	// ----------------------------------------
	localparam int RAM_AW    = 11;  // 2 KB system RAM
	localparam int EXTRAM_AW = 13;  // 8 KB extension RAM at $8000

	// ----------------------------------------
	// port block registers, taken from A1-A0
	// ----------------------------------------
	typedef logic [1:0] port_sel_t;

	localparam port_sel_t REG_ORB  = 2'd0;
	localparam port_sel_t REG_ORA  = 2'd1;
	localparam port_sel_t REG_DDRB = 2'd2;
	localparam port_sel_t REG_DDRA = 2'd3;

endpackage

`default_nettype wire

/* source/drive_clock_ctl.sv */
/*
 * Bus clock control. Picks the 1 MHz or the 2 MHz phase strobe set
 * and turns the chosen strobes into the bus rise and fall enables.
 * A change of speed halts the bus for one slow rise strobe.
 */
`timescale 1ns/1ps
`default_nettype none

module drive_clock_ctl
(
	input  wire                          clk,
	input  wire                          rst_n_i,
	input  wire drive_mode_pkg::drive_model_e model_i,
	input  wire                          accel_i,
	input  wire  [1:0]                   ph2_r_i,
	input  wire  [1:0]                   ph2_f_i,
	output logic                         bus_rise_o,
	output logic                         bus_fall_o
);
	import drive_mode_pkg::*;

	clk_state_e clk_state;
	logic       fast_tgt;  // speed to enter after the halt
	logic       sel;       // strobe set index
	logic       halt;

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			clk_state <= clk_slow;
			fast_tgt  <= 1'b0;
		end
		else if (model_i == model_1541)
		begin
			clk_state <= clk_slow;  // 1541 has no fast mode
			fast_tgt  <= 1'b0;
		end
		else if (ph2_r_i[0])
		begin
			case (clk_state)
				clk_slow:
				begin
					if (accel_i)
					begin
						clk_state <= clk_switch;
						fast_tgt  <= 1'b1;
					end
				end
				clk_fast:
				begin
					if (!accel_i)
					begin
						clk_state <= clk_switch;
						fast_tgt  <= 1'b0;
					end
				end
				default:
				begin
					clk_state <= fast_tgt ? clk_fast : clk_slow;
				end
			endcase
		end
	end

	// enables come straight from the strobes, no extra latency
	assign sel        = (clk_state == clk_fast);
	assign halt       = (clk_state == clk_switch);
	assign bus_rise_o = ph2_r_i[sel] & ~halt;
	assign bus_fall_o = ph2_f_i[sel] & ~halt;

endmodule

`default_nettype wire

/* source/drive_addr_decode.sv */
/*
 * Address decoder and read-data multiplexer for the drive CPU bus.
 * The 1541 map follows the 74LS42 decode of A15 and A12-A10, the
 * 1570/1571 map uses the wider layout. Unmapped and omitted devices
 * (FDC, CIA) read $FF.
 */
`timescale 1ns/1ps
`default_nettype none

module drive_addr_decode
(
	input  wire drive_mode_pkg::drive_model_e model_i,
	input  wire                          ext_en_i,
	input  wire drive_bus_pkg::cpu_addr_t addr_i,
	input  wire                          rw_i,
	input  wire drive_bus_pkg::cpu_data_t ram_rdata_i,
	input  wire drive_bus_pkg::cpu_data_t extram_rdata_i,
	input  wire drive_bus_pkg::cpu_data_t via1_rdata_i,
	input  wire drive_bus_pkg::cpu_data_t via2_rdata_i,
	input  wire drive_bus_pkg::cpu_data_t rom_data_i,
	output logic                         ram_cs_o,
	output logic                         extram_cs_o,
	output logic                         via1_cs_o,
	output logic                         via2_cs_o,
	output drive_bus_pkg::cpu_data_t     rdata_o
);
	import drive_mode_pkg::*;

	logic [3:0] ls42;    // decoder inputs on the 1541 board
	logic       rom_cs;

	assign ls42 = {addr_i[15], addr_i[12:10]};

	always_comb
	begin
		if (model_i == model_1541)
		begin
			ram_cs_o  = (ls42[3:2] == 2'b00);  // 2 KB mirrored up to $0fff
			via1_cs_o = (ls42 == 4'd6);
			via2_cs_o = (ls42 == 4'd7);
		end
		else
		begin
			// $2000-$5fff belongs to the FDC and CIA
			ram_cs_o  = (addr_i[15:12] == 4'h0) || (addr_i[15:13] == 3'd3);
			via1_cs_o = (addr_i[15:12] == 4'h1) && !addr_i[10];
			via2_cs_o = (addr_i[15:12] == 4'h1) && addr_i[10];
		end
	end

	assign extram_cs_o = ext_en_i && (addr_i[15:13] == 3'b100);
	assign rom_cs      = addr_i[15];

	always_comb
	begin
		if (!rw_i)
			rdata_o = 8'hFF;           // bus released on write cycles
		else if (ram_cs_o)
			rdata_o = ram_rdata_i;
		else if (via1_cs_o)
			rdata_o = via1_rdata_i;
		else if (via2_cs_o)
			rdata_o = via2_rdata_i;
		else if (extram_cs_o)
			rdata_o = extram_rdata_i;  // shadows the low ROM
		else if (rom_cs)
			rdata_o = rom_data_i;
		else
			rdata_o = 8'hFF;
	end

endmodule

`default_nettype wire

/* source/drive_ram.sv */
/*
 * Single-port RAM for the drive CPU. Write on the clock edge when
 * we_i is high, read data registered one clock after the address.
 * AW sets the size, 11 for the system RAM and 13 for the extension.
 */
`timescale 1ns/1ps
`default_nettype none

module drive_ram
#(
	parameter int AW = drive_bus_pkg::RAM_AW
)
(
	input  wire                          clk,
	input  wire                          we_i,
	input  wire  [AW-1:0]                addr_i,
	input  wire drive_bus_pkg::cpu_data_t wdata_i,
	output drive_bus_pkg::cpu_data_t     rdata_o
);
	import drive_bus_pkg::*;

	cpu_data_t mem [2**AW];

	always_ff @(posedge clk)
	begin
		if (we_i)
			mem[addr_i] <= wdata_i;
		rdata_o <= mem[addr_i];  // old data on a write cycle
	end

endmodule

`default_nettype wire

/* source/drive_port_via.sv */
/*
 * Reduced 6522 port block. Only ORB, ORA, DDRB and DDRA are kept,
 * no timers, shift register or interrupts. Pins behave open-collector
 * style, an undriven bit reads high. Registers load on the bus rise
 * enable when the block is written.
 */
`timescale 1ns/1ps
`default_nettype none

module drive_port_via
(
	input  wire                          clk,
	input  wire                          rst_n_i,
	input  wire                          wr_en_i,  // bus rise enable
	input  wire                          we_i,     // selected write cycle
	input  wire drive_bus_pkg::port_sel_t reg_i,
	input  wire drive_bus_pkg::cpu_data_t wdata_i,
	output drive_bus_pkg::cpu_data_t     rdata_o,
	input  wire drive_bus_pkg::cpu_data_t pa_i,
	input  wire drive_bus_pkg::cpu_data_t pb_i,
	output drive_bus_pkg::cpu_data_t     pa_o,
	output drive_bus_pkg::cpu_data_t     pb_o
);
	import drive_bus_pkg::*;

	cpu_data_t ora;
	cpu_data_t orb;
	cpu_data_t ddra;  // 1 = output
	cpu_data_t ddrb;
	logic      wr;

	assign wr = wr_en_i & we_i;

	// ----------------------------------------
	// register file
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			ora  <= '0;
			orb  <= '0;
			ddra <= '0;  // all pins start as inputs
			ddrb <= '0;
		end
		else if (wr)
		begin
			case (reg_i)
				REG_ORB:  orb  <= wdata_i;
				REG_ORA:  ora  <= wdata_i;
				REG_DDRB: ddrb <= wdata_i;
				REG_DDRA: ddra <= wdata_i;
				default:  ;
			endcase
		end
	end

	// ----------------------------------------
	// pins and read back
	// ----------------------------------------
	assign pa_o = ora | ~ddra;  // input bits float high
	assign pb_o = orb | ~ddrb;

	always_comb
	begin
		case (reg_i)
			REG_ORB:  rdata_o = pb_i & pb_o;  // pin level, driven low wins
			REG_ORA:  rdata_o = pa_i & pa_o;
			REG_DDRB: rdata_o = ddrb;
			default:  rdata_o = ddra;
		endcase
	end

endmodule

`default_nettype wire

/* source/drive_logic.sv */
/*
 * Board logic of a 1541/1570/1571 drive without the CPU.
 * The CPU side is a plain bus port: address, read/write and data,
 * timed by the bus rise and fall enables from the clock control.
 * Joins the decoder, the system and extension RAM, both port blocks
 * and the mapping of the port bits onto the drive pins.
 */
`timescale 1ns/1ps
`default_nettype none

module drive_logic
#(
	parameter drive_mode_pkg::drive_num_t DRIVE_NUM = 2'd0
)
(
	input  wire                          clk,
	input  wire                          rst_n_i,
	input  wire drive_mode_pkg::drive_model_e model_i,
	input  wire                          ext_en_i,
	input  wire  [1:0]                   ph2_r_i,
	input  wire  [1:0]                   ph2_f_i,
	input  wire drive_bus_pkg::cpu_addr_t cpu_addr_i,
	input  wire                          cpu_rw_i,    // 1 = read
	input  wire drive_bus_pkg::cpu_data_t cpu_wdata_i,
	output drive_bus_pkg::cpu_data_t     cpu_rdata_o,
	output logic                         bus_rise_o,
	output logic                         bus_fall_o,
	output logic [14:0]                  rom_addr_o,
	input  wire drive_bus_pkg::cpu_data_t rom_data_i,
	input  wire                          iec_atn_i,
	input  wire                          iec_clk_i,
	input  wire                          iec_data_i,
	output logic                         iec_clk_o,
	output logic                         iec_data_o,
	input  wire                          tr00_i,      // track 0 sense
	input  wire                          wps_n_i,     // write protect, active low
	output logic [1:0]                   stp_o,       // stepper phase
	output logic                         mtr_o,
	output logic                         act_o,       // activity LED
	output logic [1:0]                   freq_o,      // density select
	output logic                         side_o
);
	import drive_mode_pkg::*;
	import drive_bus_pkg::*;

	logic      accel;
	logic      cpu_wr;
	logic      ram_cs;
	logic      extram_cs;
	logic      via1_cs;
	logic      via2_cs;
	cpu_data_t ram_rdata;
	cpu_data_t extram_rdata;
	cpu_data_t via1_rdata;
	cpu_data_t via2_rdata;
	cpu_data_t via1_pa;
	cpu_data_t via1_pb;
	cpu_data_t via2_pb;
	port_sel_t via_reg;

	assign cpu_wr     = ~cpu_rw_i;
	assign via_reg    = cpu_addr_i[1:0];
	assign rom_addr_o = cpu_addr_i[14:0];

	// ----------------------------------------
	// clock, decode, memories
	// ----------------------------------------
	drive_clock_ctl clock_ctl
	(
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.model_i    (model_i),
		.accel_i    (accel),
		.ph2_r_i    (ph2_r_i),
		.ph2_f_i    (ph2_f_i),
		.bus_rise_o (bus_rise_o),
		.bus_fall_o (bus_fall_o)
	);

	drive_addr_decode addr_decode
	(
		.model_i        (model_i),
		.ext_en_i       (ext_en_i),
		.addr_i         (cpu_addr_i),
		.rw_i           (cpu_rw_i),
		.ram_rdata_i    (ram_rdata),
		.extram_rdata_i (extram_rdata),
		.via1_rdata_i   (via1_rdata),
		.via2_rdata_i   (via2_rdata),
		.rom_data_i     (rom_data_i),
		.ram_cs_o       (ram_cs),
		.extram_cs_o    (extram_cs),
		.via1_cs_o      (via1_cs),
		.via2_cs_o      (via2_cs),
		.rdata_o        (cpu_rdata_o)
	);

	drive_ram #(.AW(RAM_AW)) ram
	(
		.clk     (clk),
		.we_i    (bus_rise_o & cpu_wr & ram_cs),
		.addr_i  (cpu_addr_i[RAM_AW-1:0]),
		.wdata_i (cpu_wdata_i),
		.rdata_o (ram_rdata)
	);

	drive_ram #(.AW(EXTRAM_AW)) extram
	(
		.clk     (clk),
		.we_i    (bus_rise_o & cpu_wr & extram_cs),
		.addr_i  (cpu_addr_i[EXTRAM_AW-1:0]),
		.wdata_i (cpu_wdata_i),
		.rdata_o (extram_rdata)
	);

	// ----------------------------------------
	// VIA1, serial bus and board control
	// ----------------------------------------
	drive_port_via via1
	(
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.wr_en_i (bus_rise_o),
		.we_i    (via1_cs & cpu_wr),
		.reg_i   (via_reg),
		.wdata_i (cpu_wdata_i),
		.rdata_o (via1_rdata),
		.pa_i    ({7'h7F, ~tr00_i}),
		.pb_i    ({~iec_atn_i, DRIVE_NUM, 2'b11, ~iec_clk_i, 1'b1, ~iec_data_i}),
		.pa_o    (via1_pa),
		.pb_o    (via1_pb)
	);

	assign accel  = via1_pa[5] & (model_i != model_1541);  // 2 MHz request
	assign side_o = via1_pa[2] & (model_i == model_1571);

	// inverting drivers, so the lines are pulled low until PB1/PB3 are driven low
	assign iec_clk_o  = ~via1_pb[3];
	assign iec_data_o = ~via1_pb[1] & ~(via1_pb[4] ^ ~iec_atn_i);  // ATN ack

	// ----------------------------------------
	// VIA2, mechanics
	// ----------------------------------------
	drive_port_via via2
	(
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.wr_en_i (bus_rise_o),
		.we_i    (via2_cs & cpu_wr),
		.reg_i   (via_reg),
		.wdata_i (cpu_wdata_i),
		.rdata_o (via2_rdata),
		.pa_i    (8'hFF),                          // GCR data port not fitted
		.pb_i    ({3'b111, wps_n_i, 4'b1111}),
		.pa_o    (),
		.pb_o    (via2_pb)
	);

	assign stp_o  = via2_pb[1:0];
	assign mtr_o  = via2_pb[2];
	assign act_o  = via2_pb[3];
	assign freq_o = via2_pb[6:5];

endmodule

`default_nettype wire

/* tb/drive_logic_chk.sv */
/*
 * Concurrent assertions for the drive board logic, bound into drive_logic.
 * Watches the bus enables against the clock state and the side select
 * against the drive model. fail_cnt holds the number of failed checks.
 */
`timescale 1ns/1ps
`default_nettype none

module drive_logic_chk
(
	input wire                                clk,
	input wire                                rst_n_i,
	input wire                                bus_rise_i,
	input wire                                bus_fall_i,
	input wire drive_mode_pkg::clk_state_e    clk_state_i,
	input wire drive_mode_pkg::drive_model_e  model_i,
	input wire                                side_i
);
	import drive_mode_pkg::*;

	int unsigned fail_cnt = 0;

	a_one_enable: assert property (@(posedge clk) disable iff (!rst_n_i)
		!(bus_rise_i && bus_fall_i))
	else
	begin
		fail_cnt++;
		$error("bus_rise_o and bus_fall_o high in the same cycle");
	end

	// bus halted while the strobe set changes
	a_halt: assert property (@(posedge clk) disable iff (!rst_n_i)
		(clk_state_i == clk_switch) |-> !(bus_rise_i || bus_fall_i))
	else
	begin
		fail_cnt++;
		$error("bus enable seen during clk_switch");
	end

	a_side: assert property (@(posedge clk) disable iff (!rst_n_i)
		(model_i != model_1571) |-> !side_i)
	else
	begin
		fail_cnt++;
		$error("side_o high outside model_1571");
	end

endmodule

bind drive_logic drive_logic_chk chk
(
	.clk         (clk),
	.rst_n_i     (rst_n_i),
	.bus_rise_i  (bus_rise_o),
	.bus_fall_i  (bus_fall_o),
	.clk_state_i (clock_ctl.clk_state),
	.model_i     (model_i),
	.side_i      (side_o)
);

`default_nettype wire

/* tb/tb_drive_logic.sv */
/*
 * Testbench for the drive board logic. Plays the drive CPU on the plain
 * bus port, makes the 1 MHz and 2 MHz phase strobes and runs a table of
 * bus accesses, pin checks and bus rate checks in order.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_drive_logic;
	import drive_mode_pkg::*;
	import drive_bus_pkg::*;

	localparam drive_num_t DNUM     = 2'b10;
	localparam int         WAIT_MAX = 100;  // clocks per enable wait

	// ----------------------------------------
	// row kinds
	// ----------------------------------------
	localparam int K_WR   = 0;
	localparam int K_RD   = 1;
	localparam int K_PINS = 2;  // {iec_clk, iec_data, freq, act, mtr, stp}
	localparam int K_RATE = 3;  // bus_fall_o pulses per 64 clocks
	localparam int K_SIDE = 4;  // side_o level

	logic         clk;
	logic         rst_n;
	drive_model_e model;
	logic         ext_en;
	logic [1:0]   ph2_r;
	logic [1:0]   ph2_f;
	logic [3:0]   phase;
	cpu_addr_t    cpu_addr;
	logic         cpu_rw;
	cpu_data_t    cpu_wdata;
	cpu_data_t    cpu_rdata;
	logic         bus_rise;
	logic         bus_fall;
	logic [14:0]  rom_addr;
	cpu_data_t    rom_data;
	logic         iec_atn;
	logic         iec_clk;
	logic         iec_data;
	logic         iec_clk_out;
	logic         iec_data_out;
	logic         tr00;
	logic         wps_n;
	logic [1:0]   stp;
	logic         mtr;
	logic         act;
	logic [1:0]   freq;
	logic         side;

	int           t_kind[$];
	drive_model_e t_model[$];
	logic         t_ext[$];
	logic [4:0]   t_in[$];    // atn, clk, data, tr00, wps_n
	cpu_addr_t    t_addr[$];
	cpu_data_t    t_val[$];   // write data or expected value
	drive_model_e b_model;    // row settings while the table is built
	logic         b_ext;
	logic [4:0]   b_in;
	int           checks;
	int           errors;

	drive_logic #(.DRIVE_NUM(DNUM)) drive_logic_inst
	(
		.clk         (clk),
		.rst_n_i     (rst_n),
		.model_i     (model),
		.ext_en_i    (ext_en),
		.ph2_r_i     (ph2_r),
		.ph2_f_i     (ph2_f),
		.cpu_addr_i  (cpu_addr),
		.cpu_rw_i    (cpu_rw),
		.cpu_wdata_i (cpu_wdata),
		.cpu_rdata_o (cpu_rdata),
		.bus_rise_o  (bus_rise),
		.bus_fall_o  (bus_fall),
		.rom_addr_o  (rom_addr),
		.rom_data_i  (rom_data),
		.iec_atn_i   (iec_atn),
		.iec_clk_i   (iec_clk),
		.iec_data_i  (iec_data),
		.iec_clk_o   (iec_clk_out),
		.iec_data_o  (iec_data_out),
		.tr00_i      (tr00),
		.wps_n_i     (wps_n),
		.stp_o       (stp),
		.mtr_o       (mtr),
		.act_o       (act),
		.freq_o      (freq),
		.side_o      (side)
	);

	// ----------------------------------------
	// rules for expected values
	// ----------------------------------------
	function automatic cpu_data_t rom_byte(input logic [14:0] a);
		return a[7:0] ^ {1'b0, a[14:8]};  // folds every address bit
	endfunction

	function automatic cpu_data_t via1_pa_in(input logic [4:0] in);
		return {7'h7F, !in[1]};  // PA0 inverted track 0
	endfunction

	// ATN in on PB7, drive number PB6-PB5, clock in PB2, data in PB0
	function automatic cpu_data_t via1_pb_in(input logic [4:0] in);
		return {!in[4], DNUM, 2'b11, !in[3], 1'b1, !in[2]};
	endfunction

	function automatic cpu_data_t via2_pb_in(input logic [4:0] in);
		return {3'b111, in[0], 4'hF};  // write protect on PB4
	endfunction

	function automatic cpu_data_t pin_word(input cpu_data_t v1pb, input cpu_data_t v2pb,
		input logic atn);
		logic ack_low;
		ack_low = (v1pb[4] != !atn);  // ATN ack pulls data low
		return {!v1pb[3], !v1pb[1] && !ack_low, v2pb[6:5], v2pb[3], v2pb[2], v2pb[1:0]};
	endfunction

	assign rom_data = rom_byte(rom_addr);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// phase strobes, 1 MHz every 16 clocks and 2 MHz every 8
	always @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			phase <= 4'd0;
			ph2_r <= 2'b00;
			ph2_f <= 2'b00;
		end
		else
		begin
			phase <= phase + 4'd1;
			ph2_r <= {phase[2:0] == 3'd0, phase == 4'd0};
			ph2_f <= {phase[2:0] == 3'd4, phase == 4'd8};
		end
	end

	// ----------------------------------------
	// table
	// ----------------------------------------
	task automatic add_row(input int kind, input cpu_addr_t addr, input cpu_data_t val);
		t_kind.push_back(kind);
		t_model.push_back(b_model);
		t_ext.push_back(b_ext);
		t_in.push_back(b_in);
		t_addr.push_back(addr);
		t_val.push_back(val);
	endtask

	task automatic build_table();
		logic [31:0] r;
		cpu_addr_t   a;
		int          k;
		b_model = model_1541;
		b_ext   = 1'b0;
		b_in    = 5'b11101;  // bus released, not on track 0, no write protect
		add_row(K_PINS, 16'h0000, pin_word(8'hFF, 8'hFF, 1'b1));
		add_row(K_SIDE, 16'h0000, 8'd0);  // PA2 floats high, no side select on a 1541
		add_row(K_RD, 16'h1802, 8'h00);
		add_row(K_RD, 16'h1C02, 8'h00);
		add_row(K_RD, 16'h1000, 8'hFF);  // no device in the 1541 map
		add_row(K_RD, 16'hE123, rom_byte(15'h6123));
		add_row(K_RD, 16'h9000, rom_byte(15'h1000));
		for (k = 0; k < 3; k++)
		begin
			r = $urandom();
			a = {5'b0, r[10:0]};
			add_row(K_WR, a, r[23:16]);
			add_row(K_RD, a, r[23:16]);
			r = $urandom();
			a = {5'b0, r[10:0]};
			add_row(K_WR, 16'h4800 | a, r[31:24]);  // A14 not decoded, $0800 mirror
			add_row(K_RD, a, r[31:24]);
		end
		// VIA2 mechanics, pb = 25 | ~6F
		add_row(K_WR, 16'h1C02, 8'h6F);
		add_row(K_WR, 16'h1C00, 8'h25);
		add_row(K_RD, 16'h1C00, via2_pb_in(b_in) & 8'hB5);
		add_row(K_RD, 16'h1C02, 8'h6F);
		add_row(K_PINS, 16'h0000, pin_word(8'hFF, 8'hB5, 1'b1));
		// VIA1 serial lines
		add_row(K_WR, 16'h1802, 8'h1A);
		add_row(K_WR, 16'h1800, 8'h08);
		add_row(K_PINS, 16'h0000, pin_word(8'hED, 8'hB5, 1'b1));
		b_in = 5'b01101;
		add_row(K_PINS, 16'h0000, pin_word(8'hED, 8'hB5, 1'b0));
		add_row(K_WR, 16'h1800, 8'h10);
		add_row(K_PINS, 16'h0000, pin_word(8'hF5, 8'hB5, 1'b0));
		for (k = 0; k < 2; k++)
		begin
			b_in = (k == 0) ? 5'b00110 : 5'b11001;
			add_row(K_RD, 16'h1800, via1_pb_in(b_in) & 8'hF5);
			add_row(K_RD, 16'h1801, via1_pa_in(b_in));
			add_row(K_RD, 16'h1C00, via2_pb_in(b_in) & 8'hB5);
		end
		add_row(K_RATE, 16'h0000, 8'd4);

		b_model = model_1571;
		b_in    = 5'b11101;
		add_row(K_RATE, 16'h0000, 8'd8);  // undriven PA5 reads high
		add_row(K_SIDE, 16'h0000, 8'd1);  // undriven PA2 too
		add_row(K_RD, 16'h2000, 8'hFF);   // FDC
		add_row(K_RD, 16'h4000, 8'hFF);   // CIA
		add_row(K_RD, 16'hA000, rom_byte(15'h2000));
		for (k = 0; k < 2; k++)
		begin
			r = $urandom();
			a = {5'b0, r[10:0]};
			add_row(K_WR, 16'h6000 | a, r[23:16]);
			add_row(K_RD, a, r[23:16]);
			add_row(K_WR, 16'h0800 | a, r[31:24]);
			add_row(K_RD, 16'h7800 | a, r[31:24]);
		end
		b_ext = 1'b1;
		for (k = 0; k < 2; k++)
		begin
			r = $urandom();
			a = {3'b100, r[12:0]};
			add_row(K_WR, a, r[23:16]);
			add_row(K_RD, a, r[23:16]);
		end
		b_ext = 1'b0;
		add_row(K_RD, a, rom_byte(a[14:0]));
		add_row(K_RD, 16'h1803, 8'h00);
		add_row(K_WR, 16'h1803, 8'h24);
		add_row(K_WR, 16'h1801, 8'h00);
		add_row(K_SIDE, 16'h0000, 8'd0);
		add_row(K_RD, 16'h1003, 8'h24);  // VIA1 mirror at $1000
		add_row(K_RATE, 16'h0000, 8'd4);
		add_row(K_WR, 16'h1801, 8'h20);
		add_row(K_RATE, 16'h0000, 8'd8);
		b_model = model_1541;
		add_row(K_RATE, 16'h0000, 8'd4);
	endtask

	// ----------------------------------------
	// bus master
	// ----------------------------------------
	task automatic wait_enable(input logic want_fall, input string what);
		int   n;
		logic got;
		n = 0;
		@(negedge clk);
		got = want_fall ? bus_fall : bus_rise;
		while (!got && n < WAIT_MAX)
		begin
			@(negedge clk);
			n++;
			got = want_fall ? bus_fall : bus_rise;
		end
		if (!got)
		begin
			errors++;
			$display("timeout at %0t: no %s pulse within %0d clocks", $time, what, WAIT_MAX);
		end
	endtask

	task automatic bus_write(input cpu_addr_t addr, input cpu_data_t data);
		cpu_rw    <= 1'b0;
		cpu_addr  <= addr;
		cpu_wdata <= data;
		wait_enable(1'b0, "bus_rise_o");
		@(posedge clk);  // write edge
		cpu_rw <= 1'b1;
	endtask

	task automatic bus_read(input cpu_addr_t addr, output cpu_data_t data);
		cpu_rw   <= 1'b1;
		cpu_addr <= addr;
		wait_enable(1'b0, "bus_rise_o");
		wait_enable(1'b1, "bus_fall_o");
		data = cpu_rdata;
	endtask

	task automatic count_falls(output int cnt);
		repeat (40) @(posedge clk);  // speed change settles within two slow strobes
		cnt = 0;
		repeat (64)
		begin
			@(negedge clk);
			if (bus_fall)
				cnt++;
		end
	endtask

	task automatic check_value(input int i, input string sig, input cpu_data_t got,
		input cpu_data_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] t=%0t row %0d %s got %02h exp %02h", $time, i, sig, got, exp);
		end
		else
			$display("ok     row %0d %s = %02h", i, sig, got);
	endtask

	task automatic run_row(input int i);
		cpu_data_t got;
		int        cnt;
		@(posedge clk);
		model  <= t_model[i];
		ext_en <= t_ext[i];
		{iec_atn, iec_clk, iec_data, tr00, wps_n} <= t_in[i];
		case (t_kind[i])
			K_WR:
				bus_write(t_addr[i], t_val[i]);
			K_RD:
			begin
				bus_read(t_addr[i], got);
				check_value(i, "cpu_rdata_o", got, t_val[i]);
			end
			K_PINS:
			begin
				@(negedge clk);
				got = {iec_clk_out, iec_data_out, freq, act, mtr, stp};
				check_value(i, "drive pins", got, t_val[i]);
			end
			K_SIDE:
			begin
				@(negedge clk);
				got = {7'b0, side};
				check_value(i, "side_o", got, t_val[i]);
			end
			default:
			begin
				count_falls(cnt);
				check_value(i, "bus_fall_o count", cnt[7:0], t_val[i]);
			end
		endcase
	endtask

	initial
	begin
		int i;
		void'($urandom(67));
		checks = 0;
		errors = 0;
		rst_n     <= 1'b0;
		model     <= model_1541;
		ext_en    <= 1'b0;
		cpu_addr  <= '0;
		cpu_rw    <= 1'b1;
		cpu_wdata <= '0;
		iec_atn   <= 1'b1;
		iec_clk   <= 1'b1;
		iec_data  <= 1'b1;
		tr00      <= 1'b0;
		wps_n     <= 1'b1;
		build_table();
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		for (i = 0; i < t_kind.size(); i++)
			run_row(i);
		$display("%0d checks, %0d failed, %0d assertion failures", checks, errors,
			drive_logic_inst.chk.fail_cnt);
		if (errors == 0 && drive_logic_inst.chk.fail_cnt == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
source/drive_mode_pkg.sv
source/drive_bus_pkg.sv
source/drive_clock_ctl.sv
source/drive_addr_decode.sv
source/drive_ram.sv
source/drive_port_via.sv
source/drive_logic.sv
tb/drive_logic_chk.sv
tb/tb_drive_logic.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the drive logic testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_drive_logic -Mdir obj_dir

status=0
out=$(./obj_dir/Vtb_drive_logic +verilator+error+limit+1000 2>&1) || status=$?
echo "$out"

if grep -qx "TESTS PASSED" <<< "$out"; then
	exit 0
fi
exit 1
